/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module motor_ctrl_tb -o motor_ctrl_sim &&
./obj_dir/motor_ctrl_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src/driver_setup_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_ctrl_consts.svh"

module driver_setup_seq (
    input  wire                        clk_in,
    input  wire                        reset_n_in,
    input  wire                        restart,
    input  wire                        spi_busy,
    input  wire motor_ctrl_pkg::spi_frame_t spi_rx_frame,
    output logic                       spi_start,
    output motor_ctrl_pkg::spi_frame_t spi_tx_frame,
    output logic                       setup_done,
    output motor_ctrl_pkg::spi_frame_t last_reply
);

    localparam int GAP_W = $clog2(`MC_FRAME_GAP + 1);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`MC_FRAME_GAP - 1);
    localparam motor_ctrl_pkg::setup_idx_t IDX_LAST =
        motor_ctrl_pkg::setup_idx_t'(`MC_SETUP_COUNT - 1);

    motor_ctrl_pkg::seq_state_t state;
    motor_ctrl_pkg::setup_idx_t idx;
    logic [GAP_W-1:0] gap_cnt;
    logic frame_end;

    // busy is already high in the first wait cycle, so low means done
    assign frame_end = (state == motor_ctrl_pkg::SEQ_WAIT_BUSY) && !spi_busy;

    assign spi_start = (state == motor_ctrl_pkg::SEQ_LOAD) && !spi_busy && !restart;
    assign setup_done = (state == motor_ctrl_pkg::SEQ_DONE);

    // setup table lookup
    always_comb begin
        case (idx)
            3'd0: spi_tx_frame = `MC_SETUP_WORD_0;
            3'd1: spi_tx_frame = `MC_SETUP_WORD_1;
            3'd2: spi_tx_frame = `MC_SETUP_WORD_2;
            3'd3: spi_tx_frame = `MC_SETUP_WORD_3;
            3'd4: spi_tx_frame = `MC_SETUP_WORD_4;
            default: spi_tx_frame = '0;
        endcase
    end

    always_ff @(posedge clk_in or negedge reset_n_in) begin
        if (!reset_n_in) begin
            state <= motor_ctrl_pkg::SEQ_LOAD;
            idx <= '0;
            gap_cnt <= '0;
        end else if (restart) begin
            // start over from the first word
            state <= motor_ctrl_pkg::SEQ_LOAD;
            idx <= '0;
            gap_cnt <= '0;
        end else begin
            case (state)
                motor_ctrl_pkg::SEQ_LOAD: begin
                    if (!spi_busy) begin
                        state <= motor_ctrl_pkg::SEQ_WAIT_BUSY;
                    end
                end
                motor_ctrl_pkg::SEQ_WAIT_BUSY: begin
                    if (frame_end) begin
                        if (idx == IDX_LAST) begin
                            state <= motor_ctrl_pkg::SEQ_DONE;
                        end else begin
                            gap_cnt <= '0;
                            state <= motor_ctrl_pkg::SEQ_GAP;
                        end
                    end
                end
                motor_ctrl_pkg::SEQ_GAP: begin
                    if (gap_cnt == GAP_LAST) begin
                        gap_cnt <= '0;
                        idx <= idx + 1'b1;
                        state <= motor_ctrl_pkg::SEQ_LOAD;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                motor_ctrl_pkg::SEQ_DONE: begin
                    // stay until restart
                    state <= motor_ctrl_pkg::SEQ_DONE;
                end
                default: state <= motor_ctrl_pkg::SEQ_LOAD;
            endcase
        end
    end

    // reply of the frame that just ended
    always_ff @(posedge clk_in) begin
        if (frame_end) begin
            last_reply <= spi_rx_frame;
        end
    end

    a_idx_in_table: assert property (
        @(posedge clk_in) disable iff (!reset_n_in)
        idx < motor_ctrl_pkg::setup_idx_t'(`MC_SETUP_COUNT)
    ) else $error("setup index ran past the table");

endmodule

`default_nettype wire

/* src/motor_ctrl_consts.svh */
`ifndef MOTOR_CTRL_CONSTS_SVH
`define MOTOR_CTRL_CONSTS_SVH

// system clocks per SCLK half period
`define MC_SPI_CLK_DIV 4

// idle clocks with chip select high between frames
`define MC_FRAME_GAP 8

// number of words in the driver setup table
`define MC_SETUP_COUNT 5

// setup table, write address byte then 32 data bits
// chopconf: toff 3, hstrt 4, hend 1, tbl 2, spreadcycle
`define MC_SETUP_WORD_0 40'hEC_000100C3
// ihold_irun: ihold 10, irun 31, iholddelay 6
`define MC_SETUP_WORD_1 40'h90_00061F0A
// tpowerdown: standstill delay before current reduction
`define MC_SETUP_WORD_2 40'h91_0000000A
// gconf with en_pwm_mode set, stealthchop on
`define MC_SETUP_WORD_3 40'h80_00000004
// pwmconf: autoscale, pwm_freq 2/1024, ampl 200, grad 1
`define MC_SETUP_WORD_4 40'hF0_000401C8

// wishbone register word indices
`define MC_REG_CTRL   2'd0
`define MC_REG_HALF   2'd1
`define MC_REG_STATUS 2'd2
`define MC_REG_RESP   2'd3

`endif

/* src/motor_ctrl_pkg.sv */
`default_nettype none

package motor_ctrl_pkg;

    // one 40-bit spi frame, address or status byte on top
    typedef logic [39:0] spi_frame_t;

    // driver status byte, top of every reply
    typedef logic [7:0] status_byte_t;

    // step half period in clocks minus one
    typedef logic [31:0] half_period_t;

    // wishbone register word index and data word
    typedef logic [1:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // position in the setup table
    typedef logic [2:0] setup_idx_t;

    // spi frame engine
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SELECT,
        SPI_SHIFT,
        SPI_DESELECT
    } spi_state_t;

    // setup table walker
    typedef enum logic [1:0] {
        SEQ_LOAD,
        SEQ_WAIT_BUSY,
        SEQ_GAP,
        SEQ_DONE
    } seq_state_t;

endpackage

`default_nettype wire

/* src/motor_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_ctrl_top (
    input  wire                          clk_in,
    input  wire                          reset_n_in,
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire motor_ctrl_pkg::wb_addr_t wb_adr,
    input  wire motor_ctrl_pkg::wb_data_t wb_dat_w,
    output motor_ctrl_pkg::wb_data_t     wb_dat_r,
    output logic                         wb_ack,
    input  wire                          spi_miso,
    output logic                         spi_sclk,
    output logic                         spi_mosi,
    output logic                         spi_cs_n,
    output logic                         step
);

    logic step_enable;
    logic restart_setup;
    logic setup_done;
    logic spi_busy;
    logic spi_start;
    motor_ctrl_pkg::half_period_t half_period;
    motor_ctrl_pkg::spi_frame_t spi_tx_frame;
    motor_ctrl_pkg::spi_frame_t spi_rx_frame;
    motor_ctrl_pkg::spi_frame_t last_reply;

    // host register block
    motor_wb_regs u_regs (
        .clk_in(clk_in),
        .reset_n_in(reset_n_in),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .step_enable(step_enable),
        .half_period(half_period),
        .restart_setup(restart_setup),
        .setup_done(setup_done),
        .spi_busy(spi_busy),
        .last_reply(last_reply)
    );

    driver_setup_seq u_seq (
        .clk_in(clk_in),
        .reset_n_in(reset_n_in),
        .restart(restart_setup),
        .spi_busy(spi_busy),
        .spi_rx_frame(spi_rx_frame),
        .spi_start(spi_start),
        .spi_tx_frame(spi_tx_frame),
        .setup_done(setup_done),
        .last_reply(last_reply)
    );

    spi_master u_spi (
        .clk_in(clk_in),
        .reset_n_in(reset_n_in),
        .start(spi_start),
        .tx_frame(spi_tx_frame),
        .miso(spi_miso),
        .busy(spi_busy),
        .rx_frame(spi_rx_frame),
        .sclk(spi_sclk),
        .mosi(spi_mosi),
        .cs_n(spi_cs_n)
    );

    step_pulse_gen u_step (
        .clk_in(clk_in),
        .reset_n_in(reset_n_in),
        .enable(step_enable),
        .setup_done(setup_done),
        .half_period(half_period),
        .step(step)
    );

endmodule

`default_nettype wire

/* src/motor_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_ctrl_consts.svh"

module motor_wb_regs (
    input  wire                          clk_in,
    input  wire                          reset_n_in,
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire motor_ctrl_pkg::wb_addr_t wb_adr,
    input  wire motor_ctrl_pkg::wb_data_t wb_dat_w,
    output motor_ctrl_pkg::wb_data_t     wb_dat_r,
    output logic                         wb_ack,
    output logic                         step_enable,
    output motor_ctrl_pkg::half_period_t half_period,
    output logic                         restart_setup,
    input  wire                          setup_done,
    input  wire                          spi_busy,
    input  wire motor_ctrl_pkg::spi_frame_t last_reply
);

    motor_ctrl_pkg::status_byte_t status_byte;
    logic access;
    logic wr_en;

    // new cycle, not the one already being acked
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr_en = access && wb_we;
    assign status_byte = last_reply[39:32];

    always_ff @(posedge clk_in or negedge reset_n_in) begin
        if (!reset_n_in) begin
            wb_ack <= 1'b0;
            step_enable <= 1'b0;
            half_period <= '0;
            restart_setup <= 1'b0;
        end else begin
            wb_ack <= access;
            restart_setup <= 1'b0;
            if (wr_en) begin
                case (wb_adr)
                    `MC_REG_CTRL: begin
                        step_enable <= wb_dat_w[0];
                        restart_setup <= wb_dat_w[1];
                    end
                    `MC_REG_HALF: half_period <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    // read data lands in the ack cycle
    always_ff @(posedge clk_in) begin
        if (access && !wb_we) begin
            case (wb_adr)
                `MC_REG_CTRL: wb_dat_r <= {31'd0, step_enable};
                `MC_REG_HALF: wb_dat_r <= half_period;
                `MC_REG_STATUS: wb_dat_r <= {16'd0, status_byte, 6'd0, spi_busy, setup_done};
                `MC_REG_RESP: wb_dat_r <= last_reply[31:0];
                default: wb_dat_r <= '0;
            endcase
        end
    end

    a_ack_single: assert property (
        @(posedge clk_in) disable iff (!reset_n_in) wb_ack |=> !wb_ack
    ) else $error("wishbone ack held for two cycles");

endmodule

`default_nettype wire

/* src/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_ctrl_consts.svh"

module spi_master (
    input  wire                        clk_in,
    input  wire                        reset_n_in,
    input  wire                        start,
    input  wire motor_ctrl_pkg::spi_frame_t tx_frame,
    input  wire                        miso,
    output logic                       busy,
    output motor_ctrl_pkg::spi_frame_t rx_frame,
    output logic                       sclk,
    output logic                       mosi,
    output logic                       cs_n
);

    localparam int FRAME_BITS = $bits(motor_ctrl_pkg::spi_frame_t);
    localparam int DIV_W = $clog2(`MC_SPI_CLK_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`MC_SPI_CLK_DIV - 1);
    localparam logic [5:0] BIT_LAST = 6'(FRAME_BITS - 1);

    motor_ctrl_pkg::spi_state_t state;
    logic [DIV_W-1:0] div_cnt;
    logic [5:0] bit_cnt;
    motor_ctrl_pkg::spi_frame_t tx_shift;
    motor_ctrl_pkg::spi_frame_t rx_shift;

    logic div_last;
    logic fall_tick;
    logic rise_tick;

    assign div_last = (div_cnt == DIV_LAST);

    // falling edge puts out the next bit, rising edge samples miso
    assign fall_tick = div_last && ((state == motor_ctrl_pkg::SPI_SELECT) ||
                                    (state == motor_ctrl_pkg::SPI_SHIFT && sclk));
    assign rise_tick = div_last && (state == motor_ctrl_pkg::SPI_SHIFT) && !sclk;

    assign busy = (state != motor_ctrl_pkg::SPI_IDLE);
    assign rx_frame = rx_shift;

    always_ff @(posedge clk_in or negedge reset_n_in) begin
        if (!reset_n_in) begin
            state <= motor_ctrl_pkg::SPI_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk <= 1'b1;
            mosi <= 1'b0;
            cs_n <= 1'b1;
        end else begin
            if (state == motor_ctrl_pkg::SPI_IDLE) begin
                div_cnt <= '0;
            end else if (div_last) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            case (state)
                motor_ctrl_pkg::SPI_IDLE: begin
                    if (start) begin
                        cs_n <= 1'b0;
                        bit_cnt <= '0;
                        state <= motor_ctrl_pkg::SPI_SELECT;
                    end
                end
                motor_ctrl_pkg::SPI_SELECT: begin
                    // one half period of setup before the first edge
                    if (div_last) begin
                        sclk <= 1'b0;
                        mosi <= tx_shift[FRAME_BITS-1];
                        state <= motor_ctrl_pkg::SPI_SHIFT;
                    end
                end
                motor_ctrl_pkg::SPI_SHIFT: begin
                    if (rise_tick) begin
                        sclk <= 1'b1;
                        if (bit_cnt == BIT_LAST) begin
                            state <= motor_ctrl_pkg::SPI_DESELECT;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (fall_tick) begin
                        sclk <= 1'b0;
                        mosi <= tx_shift[FRAME_BITS-1];
                    end
                end
                motor_ctrl_pkg::SPI_DESELECT: begin
                    // hold time after the last rising edge
                    if (div_last) begin
                        cs_n <= 1'b1;
                        mosi <= 1'b0;
                        state <= motor_ctrl_pkg::SPI_IDLE;
                    end
                end
                default: state <= motor_ctrl_pkg::SPI_IDLE;
            endcase
        end
    end

    // shift registers, msb first in both directions
    always_ff @(posedge clk_in) begin
        if (state == motor_ctrl_pkg::SPI_IDLE && start) begin
            tx_shift <= tx_frame;
        end else if (fall_tick) begin
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
        end
        if (rise_tick) begin
            rx_shift <= {rx_shift[FRAME_BITS-2:0], miso};
        end
    end

    // the sequencer must honor busy before asking for a frame
    a_no_start_when_busy: assert property (
        @(posedge clk_in) disable iff (!reset_n_in) start |-> !busy
    ) else $error("spi start while a frame is in progress");

endmodule

`default_nettype wire

/* src/step_pulse_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module step_pulse_gen (
    input  wire                          clk_in,
    input  wire                          reset_n_in,
    input  wire                          enable,
    input  wire                          setup_done,
    input  wire motor_ctrl_pkg::half_period_t half_period,
    output logic                         step
);

    motor_ctrl_pkg::half_period_t cnt;
    logic run;

    // no steps before the driver is configured
    assign run = enable && setup_done;

    always_ff @(posedge clk_in or negedge reset_n_in) begin
        if (!reset_n_in) begin
            cnt <= '0;
            step <= 1'b0;
        end else if (!run) begin
            cnt <= '0;
            step <= 1'b0;
        end else if (cnt == '0) begin
            // toggle and pick up the current half period
            step <= ~step;
            cnt <= half_period;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/motor_ctrl_pkg.sv
src/spi_master.sv
src/driver_setup_seq.sv
src/step_pulse_gen.sv
src/motor_wb_regs.sv
src/motor_ctrl_top.sv
test/motor_ctrl_tb.sv

/* test/motor_ctrl_cases.txt */
# F <expected mosi frame, 40-bit hex> <miso reply for that frame, 40-bit hex>
# H <step half period, decimal> <number of step periods to measure, decimal>
F EC000100C3 0F12345678
F 9000061F0A 0100000000
F 910000000A 035A5AA5A5
F 8000000004 0087654321
F F0000401C8 813C5A96E1
H 0 4
H 1 3
H 4 3
H 13 2
H 40 2

/* test/motor_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motor_ctrl_consts.svh"

module motor_ctrl_tb;

    localparam int ACK_TIMEOUT = 20;
    localparam int FRAME_TIMEOUT = 4000;
    localparam int LOW_WINDOW = 200;

    logic clk_in = 1'b0;
    logic reset_n_in;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    motor_ctrl_pkg::wb_addr_t wb_adr;
    motor_ctrl_pkg::wb_data_t wb_dat_w;
    motor_ctrl_pkg::wb_data_t wb_dat_r;
    logic wb_ack;
    logic spi_miso;
    logic spi_sclk;
    logic spi_mosi;
    logic spi_cs_n;
    logic step;

    integer seed = 32'h8fe3_3831;

    // contents of the case file
    motor_ctrl_pkg::spi_frame_t exp_frames[$];
    motor_ctrl_pkg::spi_frame_t replies[$];
    motor_ctrl_pkg::half_period_t half_vals[$];
    int period_counts[$];

    // spi slave model
    motor_ctrl_pkg::spi_frame_t rx_frames[$];
    motor_ctrl_pkg::spi_frame_t reply_sh;
    motor_ctrl_pkg::spi_frame_t mosi_sh;
    int nbits = 0;
    int gap_cnt = 0;
    logic sclk_last = 1'b1;
    logic cs_last = 1'b1;

    motor_ctrl_top UUT (
        .clk_in(clk_in),
        .reset_n_in(reset_n_in),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .spi_miso(spi_miso),
        .spi_sclk(spi_sclk),
        .spi_mosi(spi_mosi),
        .spi_cs_n(spi_cs_n),
        .step(step)
    );

    always #2 clk_in = ~clk_in;

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        end_with_failure();
    endtask

    task automatic check_frame(input string name, input motor_ctrl_pkg::spi_frame_t exp,
                               input motor_ctrl_pkg::spi_frame_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_word(input string name, input motor_ctrl_pkg::wb_data_t exp,
                              input motor_ctrl_pkg::wb_data_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_status(input string name, input motor_ctrl_pkg::status_byte_t exp,
                                input motor_ctrl_pkg::status_byte_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_period(input string name, input motor_ctrl_pkg::half_period_t exp,
                                input motor_ctrl_pkg::half_period_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            end_with_failure();
        end
    endtask

    // F lines carry frame and reply and H lines a half period and period count
    task automatic read_cases();
        int fd;
        int code;
        string tag;
        string rest;
        motor_ctrl_pkg::spi_frame_t frame_v;
        motor_ctrl_pkg::spi_frame_t reply_v;
        motor_ctrl_pkg::half_period_t half_v;
        int count_v;
        fd = $fopen("test/motor_ctrl_cases.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open test/motor_ctrl_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1 && tag == "F") begin
                    code = $fscanf(fd, "%h %h", frame_v, reply_v);
                    exp_frames.push_back(frame_v);
                    replies.push_back(reply_v);
                end else if (code == 1 && tag == "H") begin
                    code = $fscanf(fd, "%d %d", half_v, count_v);
                    half_vals.push_back(half_v);
                    period_counts.push_back(count_v);
                end else if (code == 1) begin
                    // comment line
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // one classic cycle after a random idle gap
    task automatic bus_cycle(input logic we, input motor_ctrl_pkg::wb_addr_t adr,
                             input motor_ctrl_pkg::wb_data_t data,
                             output motor_ctrl_pkg::wb_data_t rdata);
        int gap;
        int n;
        gap = $random(seed) & 3;
        repeat (gap) @(posedge clk_in);
        @(posedge clk_in);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= data;
        n = 0;
        @(posedge clk_in);
        while (wb_ack !== 1'b1) begin
            if (n == ACK_TIMEOUT) begin
                report_failure("wishbone access got no ack within the timeout");
            end else begin
                n++;
                @(posedge clk_in);
            end
        end
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        @(posedge clk_in);
        // a second ack would show up here
        check_bit("wb_ack", 1'b0, wb_ack);
    endtask

    task automatic wb_write(input motor_ctrl_pkg::wb_addr_t adr,
                            input motor_ctrl_pkg::wb_data_t data);
        motor_ctrl_pkg::wb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input motor_ctrl_pkg::wb_addr_t adr,
                           output motor_ctrl_pkg::wb_data_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic wait_frames(input int target, input logic step_low);
        int n;
        n = 0;
        while (rx_frames.size() < target) begin
            if (n == FRAME_TIMEOUT) begin
                report_failure("setup frames did not arrive within the timeout");
            end else begin
                if (step_low) begin
                    check_bit("step", 1'b0, step);
                end
                n++;
                @(posedge clk_in);
            end
        end
    endtask

    task automatic compare_round(input int first);
        for (int i = 0; i < `MC_SETUP_COUNT; i++) begin
            check_frame("spi_mosi frame", exp_frames[i], rx_frames[first + i]);
        end
    endtask

    // clocks until the next rising edge of step
    task automatic wait_step_rise(input int limit, output int cycles);
        logic last;
        int n;
        last = step;
        @(posedge clk_in);
        n = 1;
        while (!(last === 1'b0 && step === 1'b1)) begin
            if (n >= limit) begin
                report_failure("step rising edge did not come within the timeout");
            end else begin
                last = step;
                @(posedge clk_in);
                n++;
            end
        end
        cycles = n;
    endtask

    task automatic measure_steps(input motor_ctrl_pkg::half_period_t h, input int count);
        int cyc;
        int limit;
        limit = 4 * (int'(h) + 1) + 40;
        wait_step_rise(limit, cyc);
        for (int k = 0; k < count; k++) begin
            wait_step_rise(limit, cyc);
            check_period("step period", motor_ctrl_pkg::half_period_t'(2 * (int'(h) + 1)),
                         motor_ctrl_pkg::half_period_t'(cyc));
        end
    endtask

    // slave side of the bus changes miso after a falling sclk and takes mosi after a rise
    always @(posedge clk_in) begin
        if (reset_n_in) begin
            if (cs_last && !spi_cs_n) begin
                if (rx_frames.size() > 0 && gap_cnt < `MC_FRAME_GAP) begin
                    report_failure("chip select was high for less than the frame gap");
                end
                reply_sh = replies[rx_frames.size() % replies.size()];
                mosi_sh = '0;
                nbits = 0;
            end
            if (!spi_cs_n && sclk_last && !spi_sclk) begin
                spi_miso <= reply_sh[39];
                reply_sh = {reply_sh[38:0], 1'b0};
            end
            if (!spi_cs_n && !sclk_last && spi_sclk) begin
                mosi_sh = {mosi_sh[38:0], spi_mosi};
                nbits++;
            end
            if (!cs_last && spi_cs_n) begin
                if (nbits != 40) begin
                    report_failure("spi frame did not have 40 sclk periods");
                end else begin
                    rx_frames.push_back(mosi_sh);
                end
            end
            gap_cnt = spi_cs_n ? gap_cnt + 1 : 0;
        end
        sclk_last = spi_sclk;
        cs_last = spi_cs_n;
    end

    initial begin
        motor_ctrl_pkg::wb_data_t rd;
        motor_ctrl_pkg::spi_frame_t last_reply;
        motor_ctrl_pkg::half_period_t last_half;
        reset_n_in = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        spi_miso = 1'b0;
        read_cases();
        if (exp_frames.size() != `MC_SETUP_COUNT || half_vals.size() == 0) begin
            report_failure("case file needs five F lines and at least one H line");
        end
        repeat (5) @(posedge clk_in);
        reset_n_in <= 1'b1;

        // setup table after reset
        wait_frames(`MC_SETUP_COUNT, 1'b1);
        compare_round(0);
        last_reply = replies[`MC_SETUP_COUNT - 1];
        wb_read(`MC_REG_STATUS, rd);
        check_bit("setup_done", 1'b1, rd[0]);
        check_bit("spi_busy", 1'b0, rd[1]);
        check_status("status_byte", last_reply[39:32], rd[15:8]);
        wb_read(`MC_REG_RESP, rd);
        check_word("wb_dat_r RESP", last_reply[31:0], rd);

        // step periods per H line
        foreach (half_vals[i]) begin
            wb_write(`MC_REG_CTRL, 32'd0);
            wb_write(`MC_REG_HALF, half_vals[i]);
            wb_read(`MC_REG_HALF, rd);
            check_word("wb_dat_r HALF", half_vals[i], rd);
            wb_write(`MC_REG_CTRL, 32'd1);
            wb_read(`MC_REG_CTRL, rd);
            check_word("wb_dat_r CTRL", 32'd1, rd);
            measure_steps(half_vals[i], period_counts[i]);
        end

        // step must stay low while disabled
        wb_write(`MC_REG_CTRL, 32'd0);
        repeat (LOW_WINDOW) begin
            check_bit("step", 1'b0, step);
            @(posedge clk_in);
        end
        if (rx_frames.size() != `MC_SETUP_COUNT) begin
            report_failure("spi frames were sent without a restart request");
        end

        // restart with stepping on
        last_half = half_vals[$];
        wb_write(`MC_REG_CTRL, 32'd1);
        measure_steps(last_half, 1);
        wb_write(`MC_REG_CTRL, 32'd3);
        @(posedge clk_in);
        wb_read(`MC_REG_STATUS, rd);
        check_bit("setup_done", 1'b0, rd[0]);
        wait_frames(2 * `MC_SETUP_COUNT, 1'b1);
        compare_round(`MC_SETUP_COUNT);
        wb_read(`MC_REG_STATUS, rd);
        check_bit("setup_done", 1'b1, rd[0]);
        measure_steps(last_half, 2);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
